// ==== led_macros.svh ====
`ifndef LED_MACROS_SVH
`define LED_MACROS_SVH

// number of cipher cores in the array
`define LED_NUM_CORES 4

// block width, also the plaintext and ciphertext shift count
`define LED_BLOCK_BITS 64

// key width, also the key shift count
`define LED_KEY_BITS 128

// steps of four rounds each, 48 rounds for the 128-bit key
`define LED_STEPS 12

`endif

// ==== led_cipher_pkg.sv ====
package led_cipher_pkg;

   // core control FSM
   typedef enum logic [3:0]
   {
      ctl_idle      = 4'h0,
      ctl_init      = 4'h1,   // initial key addition
      ctl_round     = 4'h2,
      ctl_shiftrow  = 4'h3,
      ctl_mixcol0   = 4'h4,
      ctl_mixcol1   = 4'h5,
      ctl_mixcol2   = 4'h6,
      ctl_mixcol3   = 4'h7,
      ctl_mixcol4   = 4'h8,   // column rotate
      ctl_nextround = 4'h9,
      ctl_addkey    = 4'ha,
      ctl_nextstep  = 4'hb
   } ctl_state_e;

   // nibble-serial datapath commands
   typedef enum logic [3:0]
   {
      cmd_idle          = 4'h0,
      cmd_hold          = 4'h1,
      cmd_loadkey       = 4'h2,
      cmd_loadpt        = 4'h3,
      cmd_getct         = 4'h4,
      cmd_addkey        = 4'h5,
      cmd_sbox          = 4'h6,
      cmd_shiftrow      = 4'h7,
      cmd_mixcolcompute = 4'h8,
      cmd_mixcolrotate  = 4'h9
   } cmd_e;

endpackage

// ==== led_host_pkg.sv ====
`include "led_macros.svh"

package led_host_pkg;

   // index of one core in the array
   typedef logic [$clog2(`LED_NUM_CORES)-1:0] core_idx_t;

   typedef enum logic [1:0]
   {
      disp_idle,
      disp_key,    // shifting key bits
      disp_pt,     // shifting plaintext bits
      disp_start
   } disp_state_e;

   typedef enum logic [1:0]
   {
      coll_idle,
      coll_shift,  // ciphertext unload
      coll_report
   } coll_state_e;

endpackage

// ==== led_core_if.sv ====
interface led_core_if;

   logic keyi;     // key bit, msb first
   logic datai;    // plaintext bit, msb first
   logic loadkey;
   logic loadpt;
   logic start;
   logic getct;
   logic dataq;    // state msb
   logic done;     // core idle

   modport core
   (
      input  keyi, datai, loadkey, loadpt, start, getct,
      output dataq, done
   );

   modport dispatch
   (
      output keyi, datai, loadkey, loadpt, start
   );

   modport collect
   (
      output getct,
      input  start, done, dataq
   );

endinterface

// ==== led_serial.sv ====
`include "led_macros.svh"

module led_serial
   (
   input  logic     clk,
   input  logic     reset,
   led_core_if.core core
   );

   logic [63:0]  state, state_next;
   logic [127:0] key, key_next;
   logic [5:0]   rc, rc_next;             // round constant lfsr
   logic [3:0]   bcount, bcount_next;     // nibble / column counter
   logic [1:0]   rcount, rcount_next;     // round within step
   logic [3:0]   scount, scount_next;     // step counter

   led_cipher_pkg::ctl_state_e ctl, ctl_next;
   led_cipher_pkg::cmd_e       cmd;

   function automatic logic [3:0] sbox(input logic [3:0] x);
      logic [3:0] y;
      case (x)
         4'h0: y = 4'hc;
         4'h1: y = 4'h5;
         4'h2: y = 4'h6;
         4'h3: y = 4'hb;
         4'h4: y = 4'h9;
         4'h5: y = 4'h0;
         4'h6: y = 4'ha;
         4'h7: y = 4'hd;
         4'h8: y = 4'h3;
         4'h9: y = 4'he;
         4'ha: y = 4'hf;
         4'hb: y = 4'h8;
         4'hc: y = 4'h4;
         4'hd: y = 4'h7;
         4'he: y = 4'h1;
         default: y = 4'h2;
      endcase
      return y;
   endfunction

   // constant for nibble position pos, key size nibbles in column 0
   function automatic logic [3:0] add_const(input logic [3:0] pos, input logic [5:0] c);
      logic [3:0] k;
      case (pos)
         4'h0: k = 4'h8;
         4'h4: k = 4'h9;
         4'h8: k = 4'h2;
         4'hc: k = 4'h3;
         4'h1, 4'h9: k = {1'b0, c[5:3]};
         4'h5, 4'hd: k = {1'b0, c[2:0]};
         default: k = 4'h0;
      endcase
      return k;
   endfunction

   // gf(16) times x, modulo x^4+x+1
   function automatic logic [3:0] fmul2(input logic [3:0] d);
      return {d[2], d[1], d[3] ^ d[0], d[3]};
   endfunction

   function automatic logic [3:0] fmul4(input logic [3:0] d);
      return fmul2(fmul2(d));
   endfunction

   always_ff @(posedge clk, negedge reset)
      if (!reset)
      begin
         ctl    <= led_cipher_pkg::ctl_idle;
         rc     <= 6'h01;
         bcount <= 4'h0;
         rcount <= 2'd0;
         scount <= 4'h0;
      end
      else
      begin
         ctl    <= ctl_next;
         rc     <= rc_next;
         bcount <= bcount_next;
         rcount <= rcount_next;
         scount <= scount_next;
      end

   always_ff @(posedge clk)
   begin
      state <= state_next;
      key   <= key_next;
   end

   always_comb
   begin
      ctl_next    = ctl;
      bcount_next = bcount;
      rcount_next = rcount;
      scount_next = scount;
      cmd         = led_cipher_pkg::cmd_hold;
      case (ctl)
         led_cipher_pkg::ctl_idle:
         begin
            if (core.loadkey)
               cmd = led_cipher_pkg::cmd_loadkey;
            else if (core.loadpt)
               cmd = led_cipher_pkg::cmd_loadpt;
            else if (core.getct)
               cmd = led_cipher_pkg::cmd_getct;
            else
               cmd = led_cipher_pkg::cmd_idle;
            bcount_next = 4'h0;
            rcount_next = 2'd0;
            scount_next = 4'h0;
            if (core.start)
               ctl_next = led_cipher_pkg::ctl_init;
         end
         led_cipher_pkg::ctl_init:
         begin
            cmd         = led_cipher_pkg::cmd_addkey;
            bcount_next = bcount + 4'h1;     // wraps after 16 nibbles
            if (bcount == 4'hf)
               ctl_next = led_cipher_pkg::ctl_round;
         end
         led_cipher_pkg::ctl_round:
         begin
            cmd         = led_cipher_pkg::cmd_sbox;
            bcount_next = bcount + 4'h1;
            if (bcount == 4'hf)
               ctl_next = led_cipher_pkg::ctl_shiftrow;
         end
         led_cipher_pkg::ctl_shiftrow:
         begin
            cmd      = led_cipher_pkg::cmd_shiftrow;
            ctl_next = led_cipher_pkg::ctl_mixcol0;
         end
         led_cipher_pkg::ctl_mixcol0,
         led_cipher_pkg::ctl_mixcol1,
         led_cipher_pkg::ctl_mixcol2,
         led_cipher_pkg::ctl_mixcol3:
         begin
            cmd      = led_cipher_pkg::cmd_mixcolcompute;
            ctl_next = led_cipher_pkg::ctl_state_e'(ctl + 4'h1);
         end
         led_cipher_pkg::ctl_mixcol4:
         begin
            cmd = led_cipher_pkg::cmd_mixcolrotate;
            if (bcount == 4'h3)
            begin
               bcount_next = 4'h0;
               ctl_next    = led_cipher_pkg::ctl_nextround;
            end
            else
            begin
               bcount_next = bcount + 4'h1;
               ctl_next    = led_cipher_pkg::ctl_mixcol0;
            end
         end
         led_cipher_pkg::ctl_nextround:
         begin
            rcount_next = rcount + 2'd1;
            ctl_next    = (rcount == 2'd3) ? led_cipher_pkg::ctl_addkey
                                           : led_cipher_pkg::ctl_round;
         end
         led_cipher_pkg::ctl_addkey:
         begin
            cmd         = led_cipher_pkg::cmd_addkey;
            bcount_next = bcount + 4'h1;
            if (bcount == 4'hf)
               ctl_next = led_cipher_pkg::ctl_nextstep;
         end
         led_cipher_pkg::ctl_nextstep:
         begin
            scount_next = scount + 4'h1;
            ctl_next    = (scount == 4'(`LED_STEPS - 1)) ? led_cipher_pkg::ctl_idle
                                                        : led_cipher_pkg::ctl_round;
         end
         default:
            ctl_next = led_cipher_pkg::ctl_idle;
      endcase
   end

   // nibble (0,0) sits in state[63:60], rows are 16-bit slices
   always_comb
   begin
      state_next = state;
      key_next   = key;
      rc_next    = rc;
      case (cmd)
         led_cipher_pkg::cmd_idle:
            rc_next = 6'h01;
         led_cipher_pkg::cmd_loadkey:
            key_next = {key[126:0], core.keyi};
         led_cipher_pkg::cmd_loadpt:
            state_next = {state[62:0], core.datai};
         led_cipher_pkg::cmd_getct:
            state_next = {state[62:0], 1'b0};
         led_cipher_pkg::cmd_addkey:
         begin
            state_next = {state[59:0], state[63:60] ^ key[127:124]};
            key_next   = {key[123:0], key[127:124]};   // halves alternate every 16
         end
         led_cipher_pkg::cmd_sbox:
            state_next = {state[59:0], sbox(state[63:60] ^ add_const(bcount, rc))};
         led_cipher_pkg::cmd_shiftrow:
         begin
            rc_next    = {rc[4:0], ~(rc[5] ^ rc[4])};
            state_next = {state[63:48],
                          state[43:32], state[47:44],
                          state[23:16], state[31:24],
                          state[3:0],   state[15:4]};
         end
         led_cipher_pkg::cmd_mixcolcompute:
         begin
            // column 0 rotates up, new bottom from row (4,1,2,2)
            state_next[63:60] = state[47:44];
            state_next[47:44] = state[31:28];
            state_next[31:28] = state[15:12];
            state_next[15:12] = fmul4(state[63:60]) ^ state[47:44] ^
                                fmul2(state[31:28]) ^ fmul2(state[15:12]);
         end
         led_cipher_pkg::cmd_mixcolrotate:
            state_next = {state[59:48], state[63:60],
                          state[43:32], state[47:44],
                          state[27:16], state[31:28],
                          state[11:0],  state[15:12]};
         default:
            state_next = state;
      endcase
   end

   assign core.done  = (ctl == led_cipher_pkg::ctl_idle);
   assign core.dataq = state[63];

endmodule

// ==== led_dispatch.sv ====
`include "led_macros.svh"

module led_dispatch
   (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        job_valid,
   input  logic [`LED_KEY_BITS-1:0]    job_key,
   input  logic [`LED_BLOCK_BITS-1:0]  job_pt,
   output logic                        job_ready,
   input  logic [`LED_NUM_CORES-1:0]   core_free,
   led_core_if.dispatch                cores [`LED_NUM_CORES]
   );

   localparam int CNT_BITS = $clog2(`LED_KEY_BITS);

   led_host_pkg::disp_state_e  state;
   led_host_pkg::core_idx_t    sel, free_idx;
   logic [CNT_BITS-1:0]        cnt;
   logic [`LED_KEY_BITS-1:0]   key_sr;
   logic [`LED_BLOCK_BITS-1:0] pt_sr;
   logic                       accept;

   // lowest free core wins
   always_comb
   begin
      free_idx = '0;
      for (int i = `LED_NUM_CORES - 1; i >= 0; i--)
         if (core_free[i])
            free_idx = led_host_pkg::core_idx_t'(i);
   end

   assign job_ready = (state == led_host_pkg::disp_idle) && (|core_free);
   assign accept    = job_valid && job_ready;

   always_ff @(posedge clk, negedge reset)
      if (!reset)
      begin
         state <= led_host_pkg::disp_idle;
         sel   <= '0;
         cnt   <= '0;
      end
      else
      begin
         case (state)
            led_host_pkg::disp_idle:
               if (accept)
               begin
                  state <= led_host_pkg::disp_key;
                  sel   <= free_idx;
                  cnt   <= '0;
               end
            led_host_pkg::disp_key:
            begin
               cnt <= cnt + 1'b1;
               if (cnt == CNT_BITS'(`LED_KEY_BITS - 1))
               begin
                  state <= led_host_pkg::disp_pt;
                  cnt   <= '0;
               end
            end
            led_host_pkg::disp_pt:
            begin
               cnt <= cnt + 1'b1;
               if (cnt == CNT_BITS'(`LED_BLOCK_BITS - 1))
                  state <= led_host_pkg::disp_start;
            end
            default:
               state <= led_host_pkg::disp_idle;   // after the start pulse
         endcase
      end

   always_ff @(posedge clk)
      if (accept)
      begin
         key_sr <= job_key;
         pt_sr  <= job_pt;
      end
      else
      begin
         if (state == led_host_pkg::disp_key)
            key_sr <= {key_sr[`LED_KEY_BITS-2:0], 1'b0};
         if (state == led_host_pkg::disp_pt)
            pt_sr <= {pt_sr[`LED_BLOCK_BITS-2:0], 1'b0};
      end

   for (genvar i = 0; i < `LED_NUM_CORES; i++)
   begin : g_core
      logic hit;

      assign hit              = (sel == led_host_pkg::core_idx_t'(i));
      assign cores[i].loadkey = hit && (state == led_host_pkg::disp_key);
      assign cores[i].loadpt  = hit && (state == led_host_pkg::disp_pt);
      assign cores[i].start   = hit && (state == led_host_pkg::disp_start);
      assign cores[i].keyi    = cores[i].loadkey && key_sr[`LED_KEY_BITS-1];
      assign cores[i].datai   = cores[i].loadpt && pt_sr[`LED_BLOCK_BITS-1];
   end

endmodule

// ==== led_collect.sv ====
`include "led_macros.svh"

module led_collect
   (
   input  logic                        clk,
   input  logic                        reset,
   led_core_if.collect                 cores [`LED_NUM_CORES],
   output logic [`LED_NUM_CORES-1:0]   core_free,
   output logic                        ct_valid,
   output logic [`LED_BLOCK_BITS-1:0]  ct_data,
   output led_host_pkg::core_idx_t     ct_core
   );

   localparam int CNT_BITS = $clog2(`LED_BLOCK_BITS);

   led_host_pkg::coll_state_e  state;
   led_host_pkg::core_idx_t    cur, pick, target;
   logic [CNT_BITS-1:0]        cnt;
   logic [`LED_NUM_CORES-1:0]  running, finished, clear;
   logic [`LED_NUM_CORES-1:0]  done_v, start_v, dataq_v;
   logic [`LED_BLOCK_BITS-1:0] ct_sr;
   logic                       unload;   // getct this cycle

   for (genvar i = 0; i < `LED_NUM_CORES; i++)
   begin : g_core
      assign done_v[i]      = cores[i].done;
      assign start_v[i]     = cores[i].start;
      assign dataq_v[i]     = cores[i].dataq;
      assign cores[i].getct = unload && (target == led_host_pkg::core_idx_t'(i));
   end

   assign finished  = running & done_v;
   assign core_free = done_v & ~running;

   always_comb
   begin
      pick = '0;
      for (int i = `LED_NUM_CORES - 1; i >= 0; i--)
         if (finished[i])
            pick = led_host_pkg::core_idx_t'(i);
   end

   // first getct goes out in the cycle the finished core is seen
   assign unload   = (state == led_host_pkg::coll_shift) ||
                     ((state == led_host_pkg::coll_idle) && (|finished));
   assign target   = (state == led_host_pkg::coll_idle) ? pick : cur;
   assign ct_valid = (state == led_host_pkg::coll_report);
   assign ct_data  = ct_sr;
   assign ct_core  = cur;
   assign clear    = {{(`LED_NUM_CORES-1){1'b0}}, ct_valid} << cur;

   always_ff @(posedge clk, negedge reset)
      if (!reset)
      begin
         state   <= led_host_pkg::coll_idle;
         running <= '0;
         cur     <= '0;
         cnt     <= '0;
      end
      else
      begin
         running <= (running & ~clear) | start_v;
         case (state)
            led_host_pkg::coll_idle:
               if (|finished)
               begin
                  state <= led_host_pkg::coll_shift;
                  cur   <= pick;
                  cnt   <= CNT_BITS'(1);
               end
            led_host_pkg::coll_shift:
            begin
               cnt <= cnt + 1'b1;
               if (cnt == CNT_BITS'(`LED_BLOCK_BITS - 1))
                  state <= led_host_pkg::coll_report;
            end
            default:
               state <= led_host_pkg::coll_idle;
         endcase
      end

   always_ff @(posedge clk)
      if (unload)
         ct_sr <= {ct_sr[`LED_BLOCK_BITS-2:0], dataq_v[target]};   // msb first

endmodule

// ==== led_array.sv ====
`include "led_macros.svh"

module led_array
   (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        job_valid,
   input  logic [`LED_KEY_BITS-1:0]    job_key,
   input  logic [`LED_BLOCK_BITS-1:0]  job_pt,
   output logic                        job_ready,
   output logic                        ct_valid,
   output logic [`LED_BLOCK_BITS-1:0]  ct_data,
   output led_host_pkg::core_idx_t     ct_core
   );

   logic [`LED_NUM_CORES-1:0] core_free;   // idle and collected

   led_core_if core_if [`LED_NUM_CORES] ();

   led_dispatch u_dispatch
      (
      .clk       (clk),
      .reset     (reset),
      .job_valid (job_valid),
      .job_key   (job_key),
      .job_pt    (job_pt),
      .job_ready (job_ready),
      .core_free (core_free),
      .cores     (core_if)
      );

   for (genvar i = 0; i < `LED_NUM_CORES; i++)
   begin : g_core
      led_serial u_core
         (
         .clk   (clk),
         .reset (reset),
         .core  (core_if[i])
         );
   end

   led_collect u_collect
      (
      .clk       (clk),
      .reset     (reset),
      .cores     (core_if),
      .core_free (core_free),
      .ct_valid  (ct_valid),
      .ct_data   (ct_data),
      .ct_core   (ct_core)
      );

endmodule

// ==== led_array_tb.sv ====
`include "led_macros.svh"

module led_array_tb;

   localparam int DRV         = 10;      // drive delay after the rising edge
   localparam int READY_LIMIT = 5000;    // cycles
   localparam int DRAIN_LIMIT = 8000;
   localparam int NUM_STREAM  = 10;

   logic                        clk;
   logic                        reset;
   logic                        job_valid;
   logic [`LED_KEY_BITS-1:0]    job_key;
   logic [`LED_BLOCK_BITS-1:0]  job_pt;
   logic                        job_ready;
   logic                        ct_valid;
   logic [`LED_BLOCK_BITS-1:0]  ct_data;
   led_host_pkg::core_idx_t     ct_core;

   logic [31:0]                 rng_state;
   logic [`LED_KEY_BITS-1:0]    stim_key;
   logic [`LED_BLOCK_BITS-1:0]  stim_pt;
   logic [`LED_NUM_CORES-1:0]   pred_free;   // model of the free core set
   logic [`LED_BLOCK_BITS-1:0]  exp_ct [$];
   int                          exp_core [$];
   int                          sent, accepted, results, idx, done_core, last_core;

   led_array DUT
      (
      .clk       (clk),
      .reset     (reset),
      .job_valid (job_valid),
      .job_key   (job_key),
      .job_pt    (job_pt),
      .job_ready (job_ready),
      .ct_valid  (ct_valid),
      .ct_data   (ct_data),
      .ct_core   (ct_core)
      );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [127:0] rand128();
      logic [127:0] v;
      v[127:96] = xorshift32();
      v[95:64]  = xorshift32();
      v[63:32]  = xorshift32();
      v[31:0]   = xorshift32();
      return v;
   endfunction

   function automatic logic [63:0] rand64();
      logic [63:0] v;
      v[63:32] = xorshift32();
      v[31:0]  = xorshift32();
      return v;
   endfunction

   function automatic logic [3:0] sbox_ref(input logic [3:0] x);
      logic [63:0] tbl;
      tbl = 64'hc56b90ad3ef84712;   // present s-box with entry 0 first
      return tbl[63-4*x -: 4];
   endfunction

   function automatic logic [3:0] gf_double(input logic [3:0] d);
      return {d[2:0], 1'b0} ^ (d[3] ? 4'h3 : 4'h0);
   endfunction

   // key size 128 in column 0 and lfsr halves in column 1
   function automatic logic [3:0] round_const(input int i, input logic [5:0] rc);
      logic [7:0] ks;
      ks = 8'h80;
      if (i % 4 == 0)
         return ((i / 4 < 2) ? ks[7:4] : ks[3:0]) ^ 4'(i / 4);
      else if (i % 4 == 1)
         return ((i / 4) % 2 == 0) ? {1'b0, rc[5:3]} : {1'b0, rc[2:0]};
      return 4'h0;
   endfunction

   function automatic logic [63:0] led_encrypt(input logic [127:0] key, input logic [63:0] pt);
      logic [3:0]  s [16];
      logic [3:0]  t [16];
      logic [3:0]  col [4];
      logic [3:0]  nb;
      logic [5:0]  rc;
      logic [63:0] res;
      rc = 6'h01;
      for (int i = 0; i < 16; i++)
         s[i] = pt[63-4*i -: 4] ^ key[127-4*i -: 4];
      for (int st = 0; st < `LED_STEPS; st++)
      begin
         for (int r = 0; r < 4; r++)
         begin
            for (int i = 0; i < 16; i++)
               s[i] = sbox_ref(s[i] ^ round_const(i, rc));
            rc = {rc[4:0], rc[5] ~^ rc[4]};
            for (int row = 0; row < 4; row++)
               for (int c = 0; c < 4; c++)
                  t[4*row+c] = s[4*row + (c+row) % 4];
            for (int c = 0; c < 4; c++)
            begin
               for (int k = 0; k < 4; k++)
                  col[k] = t[4*k+c];
               repeat (4)
               begin
                  nb = gf_double(gf_double(col[0])) ^ col[1] ^
                       gf_double(col[2]) ^ gf_double(col[3]);
                  col[0] = col[1];
                  col[1] = col[2];
                  col[2] = col[3];
                  col[3] = nb;
               end
               for (int k = 0; k < 4; k++)
                  s[4*k+c] = col[k];
            end
         end
         for (int i = 0; i < 16; i++)   // lower half first and then alternating
            s[i] = s[i] ^ ((st % 2 == 1) ? key[127-4*i -: 4] : key[63-4*i -: 4]);
      end
      for (int i = 0; i < 16; i++)
         res[63-4*i -: 4] = s[i];
      return res;
   endfunction

   function automatic int lowest_free(input logic [`LED_NUM_CORES-1:0] mask);
      int n;
      n = 0;
      for (int i = `LED_NUM_CORES - 1; i >= 0; i--)
         if (mask[i])
            n = i;
      return n;
   endfunction

   task automatic check_value(input logic [127:0] got, input logic [127:0] exp, input string what);
      if (got !== exp)
      begin
         $display("ERROR at time %0t: %s mismatch, got %0h, expected %0h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "check failed");
      end
   endtask

   task automatic timeout_abort(input string what);
      $display("timed out while waiting for %s", what);
      $display("TEST FAILED");
      $fatal(1, "timeout");
   endtask

   task automatic submit_job(input logic [127:0] key, input logic [63:0] pt);
      int waited;
      waited = 0;
      @(posedge clk);
      #DRV;
      job_valid = 1'b1;
      job_key   = key;
      job_pt    = pt;
      @(negedge clk);
      while (!job_ready)   // held strobe is ignored until ready
      begin
         waited++;
         if (waited > READY_LIMIT)
            timeout_abort("job_ready to go high");
         @(negedge clk);
      end
      @(posedge clk);
      #DRV;
      job_valid = 1'b0;
      sent++;
   endtask

   // strobe during a core load is dropped
   task automatic pulse_while_busy();
      repeat (3) @(posedge clk);
      #DRV;
      job_valid = 1'b1;
      job_key   = rand128();
      job_pt    = rand64();
      @(negedge clk);
      check_value(job_ready, 1'b0, "job_ready during core load");
      @(posedge clk);
      #DRV;
      job_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_ct.size() != 0)
      begin
         waited++;
         if (waited > DRAIN_LIMIT)
            timeout_abort("all pending results to come out");
         @(negedge clk);
      end
   endtask

   // scoreboard sampled mid-cycle
   always @(negedge clk)
      if (reset)
      begin
         if (job_valid && job_ready)
         begin
            check_value(|pred_free, 1'b1, "free core at acceptance");
            idx = lowest_free(pred_free);
            exp_ct.push_back(led_encrypt(job_key, job_pt));
            exp_core.push_back(idx);
            pred_free[idx] = 1'b0;
            accepted++;
         end
         if (ct_valid)
         begin
            check_value(exp_ct.size() > 0, 1'b1, "pending job at ct_valid");
            done_core = exp_core.pop_front();
            check_value(ct_data, exp_ct.pop_front(), "ciphertext");
            check_value(ct_core, done_core, "core index");
            pred_free[done_core] = 1'b1;   // free again from next cycle
            last_core = ct_core;
            results++;
         end
      end

   initial
   begin
      rng_state = 32'h85fe9051;
      reset     = 1'b0;
      job_valid = 1'b0;
      job_key   = '0;
      job_pt    = '0;
      pred_free = '1;
      sent      = 0;
      accepted  = 0;
      results   = 0;
      last_core = -1;
      repeat (16) @(posedge clk);
      #DRV;
      reset = 1'b1;
      @(negedge clk);
      check_value(ct_valid, 1'b0, "ct_valid after reset");
      check_value(job_ready, 1'b1, "job_ready after reset");

      stim_key = rand128();
      stim_pt  = rand64();
      submit_job(stim_key, stim_pt);
      wait_drain();
      check_value(results, 1, "single job result count");
      check_value(last_core, 0, "single job core");

      // enough jobs to fill all cores and wrap
      for (int j = 0; j < NUM_STREAM; j++)
      begin
         stim_key = rand128();
         stim_pt  = rand64();
         submit_job(stim_key, stim_pt);
         pulse_while_busy();
      end

      submit_job('0, '0);
      submit_job('1, '0);
      submit_job('0, '1);
      submit_job('1, '1);
      wait_drain();

      check_value(accepted, sent, "accepted job count");
      check_value(results, accepted, "ct_valid count");
      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+.
led_cipher_pkg.sv
led_host_pkg.sv
led_core_if.sv
led_serial.sv
led_dispatch.sv
led_collect.sv
led_array.sv
led_array_tb.sv

// ==== Bender.yml ====
package:
  name: led_array

sources:
  - include_dirs:
      - .
    files:
      - led_cipher_pkg.sv
      - led_host_pkg.sv
      - led_core_if.sv
      - led_serial.sv
      - led_dispatch.sv
      - led_collect.sv
      - led_array.sv
  - target: test
    include_dirs:
      - .
    files:
      - led_array_tb.sv
